// ==== project.f ====
+incdir+common
common/backend_pkg.sv
src/BranchControl.sv
memory/DataMemory.sv
memory/MemoryStage.sv
src/WritebackStage.sv
src/BackEnd.sv
verification/BackEnd_checker.sv
verification/BackEnd_tb.sv

// ==== Makefile ====
TOP := BackEnd_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/BackEnd_tb.sv ====
// Testbench for the pipeline back end with a reference model of writeback and branch reports.
`include "backend_defs.svh"

module BackEnd_tb;

	import backend_pkg::*;

	typedef logic [`DATA_WIDTH-1:0] dataWord;

	localparam int Timeout   = 40;
	localparam int MaxCycles = 20000;
	localparam int WordBits  = $clog2(`MEM_WORDS);

	logic                       clk;
	logic                       reset;
	logic                       inReq;
	logic                       inAck;
	dataWord                    exuResult, nextPc, branchAddr, memData;
	logic [`REG_ADDR_WIDTH-1:0] writeAddr;
	branchOp                    opSel;
	logic                       writeEn, branchCmd, branchPredict, memWrite, memValid;
	logic                       zeroFlag, negativeFlag, overflowFlag, memToReg, halt;
	logic                       branchValid, branchTaken, branchMiss, wbValid, halted;
	dataWord                    branchMissAddr, wbData;
	logic [`REG_ADDR_WIDTH-1:0] wbAddr;

	dataWord                    shadow [`MEM_WORDS];
	logic [`REG_ADDR_WIDTH-1:0] expWbAddr [$];
	dataWord                    expWbData [$];
	logic                       expTaken [$];
	logic                       expMiss [$];
	dataWord                    expMissAddr [$];
	integer                     seed;
	int                         valueErrors;
	int                         protocolErrors;
	string                      testName;

	BackEnd BackEnd_i (.branchOp(opSel), .*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic dataWord randomWord();
		return $random(seed);
	endfunction

	// signed compare table: less-than is negative differing from overflow.
	function automatic logic branchCondition(branchOp op, logic z, logic n, logic v);
		case (op)
			BrNever:  return 1'b0;
			BrAlways: return 1'b1;
			BrEq:     return z;
			BrNe:     return !z;
			BrLt:     return n != v;
			BrGe:     return n == v;
			BrLe:     return (n != v) || z;
			default:  return !((n != v) || z);
		endcase
	endfunction

	// predicts the writeback and branch report of the instruction now on the inputs.
	function automatic void modelInstruction();
		dataWord value;
		logic    taken;
		value = exuResult;
		if (memValid && memWrite) begin
			shadow[exuResult[WordBits+1:2]] = memData;
		end else if (memValid && memToReg) begin
			value = shadow[exuResult[WordBits+1:2]];
		end
		if (writeEn) begin
			expWbAddr.push_back(writeAddr);
			expWbData.push_back(value);
		end
		if (branchCmd) begin
			taken = branchCondition(opSel, zeroFlag, negativeFlag, overflowFlag);
			expTaken.push_back(taken);
			expMiss.push_back(taken != branchPredict);
			expMissAddr.push_back(branchPredict ? nextPc : branchAddr);
		end
	endfunction

	// random data fields, all control fields cleared.
	task automatic loadRandomFields();
		dataWord word;
		word          = randomWord();
		inReq         = 1'b0;
		exuResult     = randomWord();
		nextPc        = randomWord();
		branchAddr    = randomWord();
		memData       = randomWord();
		writeAddr     = word[`REG_ADDR_WIDTH-1:0];
		opSel         = branchOp'(word[7:5]);
		zeroFlag      = word[8];
		negativeFlag  = word[9];
		overflowFlag  = word[10];
		writeEn       = 1'b0;
		branchCmd     = 1'b0;
		branchPredict = 1'b0;
		memWrite      = 1'b0;
		memValid      = 1'b0;
		memToReg      = 1'b0;
		halt          = 1'b0;
	endtask

	task automatic sendInstruction();
		int count;
		modelInstruction();
		inReq = 1'b1;
		count = 0;
		do begin
			@(negedge clk);
			count++;
		end while (!inAck && count < Timeout);
		assert (inAck) else begin
			protocolErrors++;
			$display("%s: inAck never came for an instruction", testName);
		end
		inReq = 1'b0;
		count = 0;
		while (inAck && count < Timeout) begin
			@(negedge clk);
			count++;
		end
		assert (!inAck) else begin
			protocolErrors++;
			$display("%s: inAck stayed high after inReq was dropped", testName);
		end
	endtask

	task automatic drainResults();
		int count;
		count = 0;
		while ((expWbAddr.size() > 0 || expTaken.size() > 0) && count < Timeout * 4) begin
			@(negedge clk);
			count++;
		end
		assert (expWbAddr.size() == 0 && expTaken.size() == 0) else begin
			protocolErrors++;
			$display("%s: %0d writebacks and %0d branch reports never arrived",
				testName, expWbAddr.size(), expTaken.size());
		end
	endtask

	task automatic compareValue(string what, dataWord expected, dataWord actual);
		assert (expected === actual) else begin
			valueErrors++;
			$display("Error %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	// outputs change on the rising edge, so they are sampled on the falling one.
	always @(negedge clk) begin
		if (!reset && wbValid) begin
			assert (expWbAddr.size() > 0) else begin
				protocolErrors++;
				$display("%s: writeback pulse that no instruction expects", testName);
			end
			if (expWbAddr.size() > 0) begin
				compareValue("wbAddr", dataWord'(expWbAddr.pop_front()), dataWord'(wbAddr));
				compareValue("wbData", expWbData.pop_front(), wbData);
			end
		end
		if (!reset && branchValid) begin
			assert (expTaken.size() > 0) else begin
				protocolErrors++;
				$display("%s: branch report for an instruction that is no branch", testName);
			end
			if (expTaken.size() > 0) begin
				compareValue("branchTaken", dataWord'(expTaken.pop_front()), dataWord'(branchTaken));
				compareValue("branchMiss", dataWord'(expMiss.pop_front()), dataWord'(branchMiss));
				compareValue("branchMissAddr", expMissAddr.pop_front(), branchMissAddr);
			end
		end
	end

	initial begin
		int      count;
		dataWord storeAddr;
		seed           = 32'hcde5c5bb;
		valueErrors    = 0;
		protocolErrors = 0;
		testName       = "reset";
		reset          = 1'b1;
		loadRandomFields();
		for (int i = 0; i < `MEM_WORDS; i++) begin
			shadow[i] = '0;
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;

		testName = "alu writeback";
		repeat (20) begin
			loadRandomFields();
			writeEn = 1'b1;
			sendInstruction();
		end
		drainResults();

		// stores stay in the low 16 words, the upper half of memory is never written.
		testName = "store load";
		repeat (12) begin
			loadRandomFields();
			storeAddr = {22'b0, 4'b0, exuResult[3:0], 2'b00};
			exuResult = storeAddr;
			memValid  = 1'b1;
			memWrite  = 1'b1;
			sendInstruction();
			for (int k = 0; k < 2; k++) begin
				loadRandomFields();
				exuResult = (k == 0) ? storeAddr
					: {22'b0, 1'b1, exuResult[6:0], 2'b00};
				memValid  = 1'b1;
				memToReg  = 1'b1;
				writeEn   = 1'b1;
				sendInstruction();
			end
		end
		drainResults();

		testName = "branch conditions";
		for (int op = 0; op < 8; op++) begin
			repeat (4) begin
				loadRandomFields();
				opSel     = branchOp'(op[2:0]);
				branchCmd = 1'b1;
				sendInstruction();
			end
		end
		repeat (8) begin
			loadRandomFields();
			sendInstruction();
		end
		drainResults();

		testName = "misprediction";
		repeat (24) begin
			loadRandomFields();
			branchCmd     = 1'b1;
			branchPredict = nextPc[0];
			sendInstruction();
		end
		drainResults();

		testName = "no write";
		repeat (20) begin
			loadRandomFields();
			writeEn = nextPc[0];
			sendInstruction();
		end
		drainResults();

		testName = "halt";
		loadRandomFields();
		writeEn = 1'b1;
		halt    = 1'b1;
		sendInstruction();
		count = 0;
		while (!halted && count < Timeout) begin
			@(negedge clk);
			count++;
		end
		assert (halted) else begin
			protocolErrors++;
			$display("halt: halted did not rise after a halt instruction");
		end
		// this request must go unanswered, so it gets no expectation.
		loadRandomFields();
		inReq = 1'b1;
		count = 0;
		while (!inAck && count < Timeout) begin
			@(negedge clk);
			count++;
		end
		assert (!inAck) else begin
			protocolErrors++;
			$display("halt: an instruction was accepted after halt");
		end
		inReq = 1'b0;
		drainResults();
		repeat (5) @(negedge clk);

		$display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (MaxCycles) @(posedge clk);
		$display("simulation ran out of time before all tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== verification/BackEnd_checker.sv ====
// Handshake assertions for the memory stage, bound into the MemoryStage module.
`include "backend_defs.svh"

module BackEnd_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   inReq,
	input logic                   inAck,
	input logic                   memReq,
	input logic                   memAck,
	input logic                   memRw,
	input logic [`DATA_WIDTH-1:0] memAddr,
	input logic [`DATA_WIDTH-1:0] memWData
);

	// a data memory request is only withdrawn once it has been acknowledged.
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		memReq && !memAck |=> memReq)
		else $error("memReq dropped before memAck was seen");

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(memAck) |-> memReq)
		else $error("memAck rose without a pending memReq");

	// inAck is registered, so the request it answers was high on the edge before.
	inAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose while inReq was low");

	// address, data and direction must not move under an open request.
	reqStable: assert property (@(posedge clk) disable iff (reset)
		memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWData) && $stable(memRw))
		else $error("memory request fields changed while memReq was high");

endmodule

bind MemoryStage BackEnd_checker BackEnd_checker_i (
	.clk      (clk),
	.reset    (reset),
	.inReq    (inReq),
	.inAck    (inAck),
	.memReq   (memReq),
	.memAck   (memAck),
	.memRw    (memRw),
	.memAddr  (memAddr),
	.memWData (memWData)
);

// ==== src/BackEnd.sv ====
// Pipeline back end: memory stage with its data memory, followed by writeback.
`include "backend_defs.svh"

module BackEnd (
	input  logic                       clk,
	input  logic                       reset,

	input  logic                       inReq,
	input  logic [`DATA_WIDTH-1:0]     exuResult,
	input  logic [`DATA_WIDTH-1:0]     nextPc,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input  logic                       writeEn,
	input  logic [`DATA_WIDTH-1:0]     branchAddr,
	input  backend_pkg::branchOp       branchOp,
	input  logic                       branchCmd,
	input  logic                       branchPredict,
	input  logic                       zeroFlag,
	input  logic                       negativeFlag,
	input  logic                       overflowFlag,
	input  logic [`DATA_WIDTH-1:0]     memData,
	input  logic                       memWrite,
	input  logic                       memValid,
	input  logic                       memToReg,
	input  logic                       halt,
	output logic                       inAck,

	output logic                       branchValid,
	output logic                       branchTaken,
	output logic                       branchMiss,
	output logic [`DATA_WIDTH-1:0]     branchMissAddr,

	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`DATA_WIDTH-1:0]     wbData,

	output logic                       halted
);

	logic                       memReq;
	logic                       memRw;
	logic [`DATA_WIDTH-1:0]     memAddr;
	logic [`DATA_WIDTH-1:0]     memWData;
	logic                       memAck;
	logic [`DATA_WIDTH-1:0]     memRData;

	logic                       stageValid;
	logic [`DATA_WIDTH-1:0]     exuData;
	logic [`DATA_WIDTH-1:0]     memRdData;
	logic [`REG_ADDR_WIDTH-1:0] stageWriteAddr;
	logic                       stageWriteEn;
	logic                       stageMemToReg;

	MemoryStage MemoryStage_i (
		.clk            (clk),
		.reset          (reset),
		.inReq          (inReq),
		.exuResult      (exuResult),
		.nextPc         (nextPc),
		.writeAddr      (writeAddr),
		.writeEn        (writeEn),
		.branchAddr     (branchAddr),
		.branchOp       (branchOp),
		.branchCmd      (branchCmd),
		.branchPredict  (branchPredict),
		.zeroFlag       (zeroFlag),
		.negativeFlag   (negativeFlag),
		.overflowFlag   (overflowFlag),
		.memData        (memData),
		.memWrite       (memWrite),
		.memValid       (memValid),
		.memToReg       (memToReg),
		.halt           (halt),
		.inAck          (inAck),
		.memReq         (memReq),
		.memRw          (memRw),
		.memAddr        (memAddr),
		.memWData       (memWData),
		.memAck         (memAck),
		.memRData       (memRData),
		.branchValid    (branchValid),
		.branchTaken    (branchTaken),
		.branchMiss     (branchMiss),
		.branchMissAddr (branchMissAddr),
		.stageValid     (stageValid),
		.exuData        (exuData),
		.memRdData      (memRdData),
		.stageWriteAddr (stageWriteAddr),
		.stageWriteEn   (stageWriteEn),
		.stageMemToReg  (stageMemToReg),
		.halted         (halted)
	);

	DataMemory DataMemory_i (
		.clk      (clk),
		.reset    (reset),
		.memReq   (memReq),
		.memRw    (memRw),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memAck   (memAck),
		.memRData (memRData)
	);

	WritebackStage WritebackStage_i (
		.clk            (clk),
		.reset          (reset),
		.stageValid     (stageValid),
		.exuData        (exuData),
		.memRdData      (memRdData),
		.stageWriteAddr (stageWriteAddr),
		.stageWriteEn   (stageWriteEn),
		.stageMemToReg  (stageMemToReg),
		.wbValid        (wbValid),
		.wbAddr         (wbAddr),
		.wbData         (wbData)
	);

endmodule

// ==== src/WritebackStage.sv ====
// Writeback stage: picks memory or ALU data and drives the register write port.
`include "backend_defs.svh"

module WritebackStage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       stageValid,
	input  logic [`DATA_WIDTH-1:0]     exuData,
	input  logic [`DATA_WIDTH-1:0]     memRdData,
	input  logic [`REG_ADDR_WIDTH-1:0] stageWriteAddr,
	input  logic                       stageWriteEn,
	input  logic                       stageMemToReg,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`DATA_WIDTH-1:0]     wbData
);

	// instructions that write no register still pass through, only the pulse is dropped.
	always_ff @(posedge clk) begin
		if (reset) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= stageValid & stageWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		if (stageValid) begin
			wbAddr <= stageWriteAddr;
			wbData <= stageMemToReg ? memRdData : exuData;
		end
	end

endmodule

// ==== memory/MemoryStage.sv ====
// Memory stage: accepts instructions, resolves branches and sequences data memory access.
`include "backend_defs.svh"

module MemoryStage (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        inReq,
	input  logic [`DATA_WIDTH-1:0]      exuResult,
	input  logic [`DATA_WIDTH-1:0]      nextPc,
	input  logic [`REG_ADDR_WIDTH-1:0]  writeAddr,
	input  logic                        writeEn,
	input  logic [`DATA_WIDTH-1:0]      branchAddr,
	input  backend_pkg::branchOp        branchOp,
	input  logic                        branchCmd,
	input  logic                        branchPredict,
	input  logic                        zeroFlag,
	input  logic                        negativeFlag,
	input  logic                        overflowFlag,
	input  logic [`DATA_WIDTH-1:0]      memData,
	input  logic                        memWrite,
	input  logic                        memValid,
	input  logic                        memToReg,
	input  logic                        halt,
	output logic                        inAck,

	output logic                        memReq,
	output logic                        memRw,
	output logic [`DATA_WIDTH-1:0]      memAddr,
	output logic [`DATA_WIDTH-1:0]      memWData,
	input  logic                        memAck,
	input  logic [`DATA_WIDTH-1:0]      memRData,

	output logic                        branchValid,
	output logic                        branchTaken,
	output logic                        branchMiss,
	output logic [`DATA_WIDTH-1:0]      branchMissAddr,

	output logic                        stageValid,
	output logic [`DATA_WIDTH-1:0]      exuData,
	output logic [`DATA_WIDTH-1:0]      memRdData,
	output logic [`REG_ADDR_WIDTH-1:0]  stageWriteAddr,
	output logic                        stageWriteEn,
	output logic                        stageMemToReg,
	output logic                        halted
);

	import backend_pkg::*;

	memState state;
	logic    taken;
	logic    capture;
	logic    haltPending;

	BranchControl BranchControl_i (
		.branchOp     (branchOp),
		.branchCmd    (branchCmd),
		.zeroFlag     (zeroFlag),
		.negativeFlag (negativeFlag),
		.overflowFlag (overflowFlag),
		.taken        (taken)
	);

	// a new instruction is taken only between handshakes and while nothing is in flight.
	assign capture = inReq & ~inAck & (state == Idle);

	// the ALU result is the data memory address.
	assign memAddr = exuData;
	assign halted  = (state == Halted);

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= Idle;
			inAck       <= 1'b0;
			memReq      <= 1'b0;
			stageValid  <= 1'b0;
			branchValid <= 1'b0;
			haltPending <= 1'b0;
		end else begin
			stageValid  <= 1'b0;
			branchValid <= 1'b0;

			if (capture) begin
				inAck <= 1'b1;
			end else if (inAck && !inReq) begin
				inAck <= 1'b0;
			end

			case (state)
				Idle: begin
					if (capture) begin
						branchValid <= branchCmd;
						haltPending <= halt;
						if (memValid) begin
							memReq <= 1'b1;
							state  <= Request;
						end else begin
							// no memory access, so hand over to writeback right away.
							stageValid <= 1'b1;
							state      <= halt ? Halted : Idle;
						end
					end
				end
				Request: begin
					if (memAck) begin
						memReq     <= 1'b0;
						stageValid <= 1'b1;
						state      <= Release;
					end
				end
				Release: begin
					if (!memAck) begin
						state <= haltPending ? Halted : Idle;
					end
				end
				Halted: begin
					state <= Halted;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			exuData        <= exuResult;
			memWData       <= memData;
			memRw          <= memWrite;
			stageWriteAddr <= writeAddr;
			stageWriteEn   <= writeEn;
			stageMemToReg  <= memToReg;
			branchTaken    <= taken;
			branchMiss     <= taken ^ branchPredict;
			// a wrong taken guess resumes at the fall-through address.
			branchMissAddr <= branchPredict ? nextPc : branchAddr;
		end
		if (state == Request && memAck) begin
			memRdData <= memRData;
		end
	end

endmodule

// ==== memory/DataMemory.sv ====
// Word-addressed data RAM answering four-phase requests after a fixed delay.
`include "backend_defs.svh"

module DataMemory (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   memReq,
	input  logic                   memRw,
	input  logic [`DATA_WIDTH-1:0] memAddr,
	input  logic [`DATA_WIDTH-1:0] memWData,
	output logic                   memAck,
	output logic [`DATA_WIDTH-1:0] memRData
);

	localparam int Latency    = `MEM_LATENCY;
	localparam int AddrBits   = $clog2(`MEM_WORDS);
	localparam int CountWidth = $clog2(Latency + 1);

	logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS];
	logic [CountWidth-1:0]  count;
	logic [AddrBits-1:0]    wordAddr;
	logic                   fire;

	// byte address to word index, the two low bits select a byte and are dropped.
	assign wordAddr = memAddr[AddrBits+1:2];

	// the access happens on the last counted cycle of a held request.
	assign fire = memReq & ~memAck & (count == CountWidth'(Latency - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			memAck <= 1'b0;
		end else if (!memReq) begin
			count  <= '0;
			memAck <= 1'b0;
		end else if (fire) begin
			memAck <= 1'b1;
		end else if (!memAck) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (fire && memRw) begin
			mem[wordAddr] <= memWData;
		end
	end

	// read data stays put for as long as the acknowledge is high.
	always_ff @(posedge clk) begin
		if (fire && !memRw) begin
			memRData <= mem[wordAddr];
		end
	end

endmodule

// ==== src/BranchControl.sv ====
// Branch condition evaluation from the zero, negative and overflow flags.
module BranchControl (
	input  backend_pkg::branchOp branchOp,
	input  logic                 branchCmd,
	input  logic                 zeroFlag,
	input  logic                 negativeFlag,
	input  logic                 overflowFlag,
	output logic                 taken
);

	import backend_pkg::*;

	logic lessThan;
	logic condition;

	// a signed less-than holds when the sign of the difference is wrong by overflow.
	assign lessThan = negativeFlag ^ overflowFlag;

	always_comb begin
		case (branchOp)
			BrNever:  condition = 1'b0;
			BrAlways: condition = 1'b1;
			BrEq:     condition = zeroFlag;
			BrNe:     condition = ~zeroFlag;
			BrLt:     condition = lessThan;
			BrGe:     condition = ~lessThan;
			BrLe:     condition = lessThan | zeroFlag;
			BrGt:     condition = ~(lessThan | zeroFlag);
			default:  condition = 1'b0;
		endcase
	end

	// only real branch instructions may report a taken branch.
	assign taken = branchCmd & condition;

endmodule

// ==== common/backend_pkg.sv ====
// Back end types shared by the memory stage, branch logic and verification.
package backend_pkg;

	// branch conditions, evaluated from the ALU flags of a signed compare.
	typedef enum logic [2:0] {
		BrNever  = 3'd0,
		BrAlways = 3'd1,
		BrEq     = 3'd2,
		BrNe     = 3'd3,
		BrLt     = 3'd4,
		BrGe     = 3'd5,
		BrLe     = 3'd6,
		BrGt     = 3'd7
	} branchOp;

	// memory stage sequencer.
	// Request holds memReq until the acknowledge, Release waits for it to drop.
	typedef enum logic [1:0] {
		Idle    = 2'd0,
		Request = 2'd1,
		Release = 2'd2,
		Halted  = 2'd3
	} memState;

endpackage

// ==== common/backend_defs.svh ====
// Sizing constants for the back end datapath and data memory.
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// width of data words and byte addresses.
`define DATA_WIDTH 32

// width of a destination register number.
`define REG_ADDR_WIDTH 5

// data memory depth in words.
`define MEM_WORDS 256

// cycles from the first sight of a request to the acknowledge.
`define MEM_LATENCY 2

`endif
